/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
OBJ_DIR   ?= obj_dir
FILELIST  ?= vlog.f
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

SIM     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard common/*.svh)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* common/rv_defines.svh */
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath width
`define RV_XLEN 32

// register number for x0..x31
`define RV_REG_W 5

// major opcode field
`define RV_OPC_W 7

// funct fields
`define RV_F3_W 3
`define RV_F7_W 7

`endif

/* common/rv_pkg.sv */
`include "rv_defines.svh"

package rv_pkg;

	typedef logic [`RV_XLEN-1:0]  data_t;
	typedef logic [`RV_REG_W-1:0] reg_idx_t;
	typedef logic [`RV_F3_W-1:0]  funct3_t;
	typedef logic [`RV_F7_W-1:0]  funct7_t;

	typedef enum logic [`RV_OPC_W-1:0] {
		R     = 7'b0110011,
		I     = 7'b0010011,
		B     = 7'b1100011,
		LUI   = 7'b0110111,
		AUIPC = 7'b0010111,
		JAL   = 7'b1101111,
		JALR  = 7'b1100111,
		LOAD  = 7'b0000011,
		STORE = 7'b0100011,
		MEM   = 7'b0001111, // fence
		SYS   = 7'b1110011
	} opcode_t;

	typedef struct packed {
		opcode_t  opcode;
		funct3_t  funct3;
		funct7_t  funct7;
		reg_idx_t rs1;
		reg_idx_t rs2;
		reg_idx_t rd;
	} instr_t;

	typedef enum logic [1:0] {
		RS_SEL          = 2'b00,
		MEM_MEM_FWD_SEL = 2'b01, // store data forwarding never produced
		EX_EX_FWD_SEL   = 2'b10,
		MEM_EX_FWD_SEL  = 2'b11
	} fwd_sel_t;

	typedef enum logic [3:0] {
		ADD, SUB, SLL, SLT,
		SLTU, XOR, SRL, SRA,
		OR, AND, BEQ, BNE,
		BLT, BGE, BLTU, BGEU
	} alu_op_t;

	localparam data_t NULL = '0;

endpackage

/* execute/alu.sv */
`timescale 1ns/1ps
`include "rv_defines.svh"

module alu (
	input  rv_pkg::alu_op_t alu_op,
	input  rv_pkg::data_t   a,
	input  rv_pkg::data_t   b,
	output rv_pkg::data_t   result,
	output logic            branch_cond
);
	import rv_pkg::*;

	localparam int shamt_w = $clog2(`RV_XLEN);

	logic [shamt_w-1:0] shamt;
	logic lt_s, lt_u, eq;

	assign shamt = b[shamt_w-1:0];
	assign eq    = (a == b);
	assign lt_s  = ($signed(a) < $signed(b));
	assign lt_u  = (a < b);

	always_comb begin : alu_core
		result      = NULL;
		branch_cond = 1'b0;
		case (alu_op)
			ADD:  result = a + b;
			SUB:  result = a - b;
			SLL:  result = a << shamt;
			SLT:  result = data_t'(lt_s);
			SLTU: result = data_t'(lt_u);
			XOR:  result = a ^ b;
			SRL:  result = a >> shamt;
			SRA:  result = data_t'($signed(a) >>> shamt);
			OR:   result = a | b;
			AND:  result = a & b;
			// compares only raise the flag, result stays zero
			BEQ:  branch_cond = eq;
			BNE:  branch_cond = !eq;
			BLT:  branch_cond = lt_s;
			BGE:  branch_cond = !lt_s;
			BLTU: branch_cond = lt_u;
			BGEU: branch_cond = !lt_u;
			default: begin
				result      = NULL;
				branch_cond = 1'b0;
			end
		endcase
	end

endmodule

/* execute/alu_ctrl.sv */
`timescale 1ns/1ps

module alu_ctrl (
	input  rv_pkg::instr_t  instr,
	output rv_pkg::alu_op_t alu_op,
	output logic            rd_we
);
	import rv_pkg::*;

	logic alt; // funct7[5] selects sub and sra
	logic writes;

	assign alt = instr.funct7[5];

	always_comb begin : op_dec
		alu_op = ADD;
		case (instr.opcode)
			R, I: begin
				case (instr.funct3)
					3'b000:  alu_op = (alt && instr.opcode == R) ? SUB : ADD;
					3'b001:  alu_op = SLL;
					3'b010:  alu_op = SLT;
					3'b011:  alu_op = SLTU;
					3'b100:  alu_op = XOR;
					3'b101:  alu_op = alt ? SRA : SRL;
					3'b110:  alu_op = OR;
					default: alu_op = AND;
				endcase
			end
			B: begin
				case (instr.funct3)
					3'b000:  alu_op = BEQ;
					3'b001:  alu_op = BNE;
					3'b100:  alu_op = BLT;
					3'b101:  alu_op = BGE;
					3'b110:  alu_op = BLTU;
					3'b111:  alu_op = BGEU;
					default: alu_op = ADD; // reserved encodings never branch
				endcase
			end
			default: alu_op = ADD;
		endcase
	end

	always_comb begin : we_dec
		case (instr.opcode)
			R, I, LUI, AUIPC, JAL, JALR, LOAD: writes = 1'b1;
			default:                           writes = 1'b0;
		endcase
	end

	assign rd_we = writes && (instr.rd != '0); // x0 is hardwired

endmodule

/* execute/ex_mux.sv */
`timescale 1ns/1ps

module ex_mux (
	input  rv_pkg::instr_t   instr,
	input  rv_pkg::data_t    pc,
	input  rv_pkg::data_t    rs1,
	input  rv_pkg::data_t    rs2,
	input  rv_pkg::data_t    imm,
	input  rv_pkg::data_t    ex_ex_fwd_data,
	input  rv_pkg::data_t    mem_ex_fwd_data,

	input  rv_pkg::fwd_sel_t fwd_a,
	input  rv_pkg::fwd_sel_t fwd_b,

	output rv_pkg::data_t    a_out,
	output rv_pkg::data_t    b_out
);
	import rv_pkg::*;

	localparam logic [1:0] null_sel = 2'b00;
	localparam logic [1:0] reg_sel  = 2'b10;
	localparam logic [1:0] pc_sel   = 2'b11; // a side only
	localparam logic [1:0] imm_sel  = 2'b11; // b side only

	logic [1:0] a_sel, b_sel;
	data_t a_pre, b_pre;

	// operand source by opcode
	always_comb begin : src_sel
		a_sel = null_sel;
		b_sel = null_sel;
		case (instr.opcode)
			R, B: begin
				a_sel = reg_sel;
				b_sel = reg_sel;
			end
			I, LOAD, STORE: begin // rs1 + imm
				a_sel = reg_sel;
				b_sel = imm_sel;
			end
			LUI: begin // 0 + imm
				a_sel = null_sel;
				b_sel = imm_sel;
			end
			AUIPC, JAL, JALR: begin // jumps get imm = 4
				a_sel = pc_sel;
				b_sel = imm_sel;
			end
			default: begin // MEM, SYS
				a_sel = null_sel;
				b_sel = null_sel;
			end
		endcase
	end

	always_comb begin : a_src_mux
		case (a_sel)
			reg_sel: a_pre = rs1;
			pc_sel:  a_pre = pc;
			default: a_pre = NULL;
		endcase
	end

	always_comb begin : b_src_mux
		case (b_sel)
			reg_sel: b_pre = rs2;
			imm_sel: b_pre = imm;
			default: b_pre = NULL;
		endcase
	end

	always_comb begin : fwd_a_mux
		case (fwd_a)
			EX_EX_FWD_SEL:  a_out = ex_ex_fwd_data;
			MEM_EX_FWD_SEL: a_out = mem_ex_fwd_data;
			default:        a_out = a_pre; // RS_SEL, MEM_MEM_FWD_SEL
		endcase
	end

	always_comb begin : fwd_b_mux
		case (fwd_b)
			EX_EX_FWD_SEL:  b_out = ex_ex_fwd_data;
			MEM_EX_FWD_SEL: b_out = mem_ex_fwd_data;
			default:        b_out = b_pre;
		endcase
	end

endmodule

/* execute/fwd_unit.sv */
`timescale 1ns/1ps

module fwd_unit (
	input  rv_pkg::instr_t   id_ex_instr,
	input  logic             ex_valid,
	input  logic             ex_we,
	input  rv_pkg::reg_idx_t ex_rd,
	input  logic             wb_we,
	input  rv_pkg::reg_idx_t wb_rd,
	output rv_pkg::fwd_sel_t fwd_a,
	output rv_pkg::fwd_sel_t fwd_b
);
	import rv_pkg::*;

	logic rs1_used, rs2_used;
	logic ex_hit_ok, wb_hit_ok;

	// must agree with the operand table in ex_mux
	always_comb begin : use_dec
		case (id_ex_instr.opcode)
			R, B: begin
				rs1_used = 1'b1;
				rs2_used = 1'b1;
			end
			I, LOAD, STORE: begin // b side is imm
				rs1_used = 1'b1;
				rs2_used = 1'b0;
			end
			default: begin
				rs1_used = 1'b0;
				rs2_used = 1'b0;
			end
		endcase
	end

	assign ex_hit_ok = ex_valid && ex_we && (ex_rd != '0);
	assign wb_hit_ok = wb_we && (wb_rd != '0);

	function automatic fwd_sel_t pick(input logic used, input reg_idx_t rs);
		fwd_sel_t sel;
		sel = RS_SEL;
		if (used && ex_hit_ok && ex_rd == rs)
			sel = EX_EX_FWD_SEL; // newest value wins
		else if (used && wb_hit_ok && wb_rd == rs)
			sel = MEM_EX_FWD_SEL;
		return sel;
	endfunction

	always_comb begin : fwd_sel
		fwd_a = pick(rs1_used, id_ex_instr.rs1);
		fwd_b = pick(rs2_used, id_ex_instr.rs2);
	end

endmodule

/* src/ex_stage.sv */
`timescale 1ns/1ps

module ex_stage (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             stall,

	input  logic             id_valid,
	input  rv_pkg::instr_t   id_instr,
	input  rv_pkg::data_t    id_pc,
	input  rv_pkg::data_t    id_rs1_data,
	input  rv_pkg::data_t    id_rs2_data,
	input  rv_pkg::data_t    id_imm,

	input  logic             wb_we,
	input  rv_pkg::reg_idx_t wb_rd,
	input  rv_pkg::data_t    wb_data,

	output logic             ex_valid,
	output rv_pkg::data_t    ex_result,
	output rv_pkg::reg_idx_t ex_rd,
	output logic             ex_we,
	output logic             ex_branch_taken
);
	import rv_pkg::*;

	// ID/EX register
	logic   id_ex_valid;
	instr_t id_ex_instr;
	data_t  id_ex_pc, id_ex_rs1, id_ex_rs2, id_ex_imm;

	fwd_sel_t fwd_a, fwd_b;
	data_t    alu_a, alu_b, alu_result;
	alu_op_t  alu_op;
	logic     rd_we, branch_cond;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			id_ex_valid <= 1'b0;
			id_ex_instr <= '0;
			id_ex_pc    <= NULL;
			id_ex_rs1   <= NULL;
			id_ex_rs2   <= NULL;
			id_ex_imm   <= NULL;
		end else if (!stall) begin
			id_ex_valid <= id_valid;
			id_ex_instr <= id_instr;
			id_ex_pc    <= id_pc;
			id_ex_rs1   <= id_rs1_data;
			id_ex_rs2   <= id_rs2_data;
			id_ex_imm   <= id_imm;
		end
	end

	fwd_unit fwd_i (
		.id_ex_instr(id_ex_instr),
		.ex_valid   (ex_valid),
		.ex_we      (ex_we),
		.ex_rd      (ex_rd),
		.wb_we      (wb_we),
		.wb_rd      (wb_rd),
		.fwd_a      (fwd_a),
		.fwd_b      (fwd_b)
	);

	ex_mux mux_i (
		.instr          (id_ex_instr),
		.pc             (id_ex_pc),
		.rs1            (id_ex_rs1),
		.rs2            (id_ex_rs2),
		.imm            (id_ex_imm),
		.ex_ex_fwd_data (ex_result),
		.mem_ex_fwd_data(wb_data),
		.fwd_a          (fwd_a),
		.fwd_b          (fwd_b),
		.a_out          (alu_a),
		.b_out          (alu_b)
	);

	alu_ctrl ctrl_i (
		.instr (id_ex_instr),
		.alu_op(alu_op),
		.rd_we (rd_we)
	);

	alu alu_i (
		.alu_op     (alu_op),
		.a          (alu_a),
		.b          (alu_b),
		.result     (alu_result),
		.branch_cond(branch_cond)
	);

	// EX/MEM register
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid        <= 1'b0;
			ex_result       <= NULL;
			ex_rd           <= '0;
			ex_we           <= 1'b0;
			ex_branch_taken <= 1'b0;
		end else if (!stall) begin
			ex_valid        <= id_ex_valid;
			ex_result       <= alu_result;
			ex_rd           <= id_ex_instr.rd;
			ex_we           <= id_ex_valid && rd_we; // bubbles never write
			ex_branch_taken <= id_ex_valid && branch_cond;
		end
	end

endmodule

/* verification/ex_trace.txt */
# hex: stall valid opcode f3 f7 rs1 rs2 rd pc rs1_data rs2_data imm wb_we wb_rd wb_data
# wb_* serve the instr accepted one line earlier; last five: exp valid result rd we br
0 1 33 0 00 01 02 0a 00000000 00000005 00000003 00000000 0 00 00000000 1 00000008 0a 1 0
0 1 33 0 20 01 02 0b 00000000 00000003 00000005 00000000 0 00 00000000 1 fffffffe 0b 1 0
0 1 33 1 00 01 02 0c 00000000 00000001 00000024 00000000 0 00 00000000 1 00000010 0c 1 0
0 1 33 2 00 01 02 0d 00000000 ffffffff 00000001 00000000 0 00 00000000 1 00000001 0d 1 0
0 1 33 3 00 01 02 0e 00000000 ffffffff 00000001 00000000 0 00 00000000 1 00000000 0e 1 0
0 1 33 4 00 01 02 0f 00000000 f0f0f0f0 ff00ff00 00000000 0 00 00000000 1 0ff00ff0 0f 1 0
0 1 33 5 00 01 02 10 00000000 80000000 00000004 00000000 0 00 00000000 1 08000000 10 1 0
0 1 33 5 20 01 02 11 00000000 80000000 00000004 00000000 0 00 00000000 1 f8000000 11 1 0
0 1 33 6 00 01 02 12 00000000 00f0000f 0f000f00 00000000 0 00 00000000 1 0ff00f0f 12 1 0
0 1 33 7 00 01 02 13 00000000 f0f0f0f0 ff00ff00 00000000 0 00 00000000 1 f000f000 13 1 0
0 1 13 0 20 01 00 14 00000000 00000010 00000000 fffffffc 0 00 00000000 1 0000000c 14 1 0
0 1 13 5 20 01 00 15 00000000 f0000000 00000000 00000404 0 00 00000000 1 ff000000 15 1 0
0 1 13 2 00 01 00 16 00000000 00000005 00000000 00000007 0 00 00000000 1 00000001 16 1 0
0 1 37 0 00 00 00 17 00000000 deadbeef 00000000 12345000 0 00 00000000 1 12345000 17 1 0
0 1 17 0 00 00 00 18 00001000 00000000 00000000 00002000 0 00 00000000 1 00003000 18 1 0
0 1 6f 0 00 00 00 19 00000100 00000000 00000000 00000004 0 00 00000000 1 00000104 19 1 0
0 1 67 0 00 02 00 1a 00000200 12345678 00000000 00000004 0 00 00000000 1 00000204 1a 1 0
0 1 03 2 00 03 00 1b 00000000 00001000 00000000 00000010 0 00 00000000 1 00001010 1b 1 0
0 1 23 2 00 03 04 00 00000000 00002000 0000abcd fffffff8 0 00 00000000 1 00001ff8 00 0 0
0 1 0f 0 00 00 00 00 00000000 11111111 22222222 00000000 0 00 00000000 1 00000000 00 0 0
0 1 73 0 00 01 02 1c 00000300 33333333 44444444 00000001 0 00 00000000 1 00000000 1c 0 0
0 1 33 0 00 01 02 05 00000000 00000001 00000002 00000000 0 00 00000000 1 00000003 05 1 0
0 1 33 0 00 05 02 06 00000000 00000099 00000010 00000000 0 00 00000000 1 00000013 06 1 0
0 1 33 0 00 03 05 07 00000000 00000100 0000aaaa 00000000 0 00 00000000 1 00000103 07 1 0
0 1 33 0 20 07 01 08 00000000 00000000 00000003 00000000 1 05 00000003 1 00000100 08 1 0
0 1 33 0 00 01 02 00 00000000 00000011 00000022 00000000 1 07 0000dead 1 00000033 00 0 0
0 1 33 0 00 00 00 09 00000000 00000000 00000000 00000000 0 00 00000000 1 00000000 09 1 0
0 1 37 0 00 09 09 12 00000000 00000000 00000000 0abcd000 1 00 0000beef 1 0abcd000 12 1 0
0 1 63 0 00 01 02 00 00000000 00000005 00000005 00000000 1 09 00000077 1 00000000 00 0 1
0 1 63 1 00 01 02 00 00000000 00000005 00000005 00000000 0 00 00000000 1 00000000 00 0 0
0 1 63 4 00 01 02 00 00000000 ffffffff 00000001 00000000 0 00 00000000 1 00000000 00 0 1
0 1 63 5 00 01 02 00 00000000 ffffffff 00000001 00000000 0 00 00000000 1 00000000 00 0 0
0 1 63 6 00 01 02 00 00000000 ffffffff 00000001 00000000 0 00 00000000 1 00000000 00 0 0
0 1 63 7 00 01 02 00 00000000 ffffffff 00000001 00000000 0 00 00000000 1 00000000 00 0 1
0 1 33 0 00 01 02 13 00000000 00000100 00000001 00000000 0 00 00000000 1 00000101 13 1 0
1 1 33 0 00 01 02 1d 00000000 0000ffff 0000ffff 00000000 0 00 00000000 1 0001fffe 1d 1 0
1 1 13 0 00 01 00 1e 00000000 00000001 00000000 00000001 0 00 00000000 1 00000002 1e 1 0
0 1 33 0 00 13 02 14 00000000 00000000 00000002 00000000 0 00 00000000 1 00000103 14 1 0
0 0 33 0 00 00 00 15 00000000 00000000 00000000 00000000 0 00 00000000 0 00000000 15 0 0
0 1 33 0 00 15 02 16 00000000 00000007 00000001 00000000 0 00 00000000 1 00000008 16 1 0

/* verification/tb_ex_stage.sv */
`timescale 1ns/1ps

module tb_ex_stage;
	import rv_pkg::*;

	localparam string trace_file = "verification/ex_trace.txt";

	typedef struct packed {
		logic     valid;
		data_t    result;
		reg_idx_t rd;
		logic     we;
		logic     br;
	} expect_t;

	logic     clk;
	logic     rst_n;
	logic     stall;
	logic     id_valid;
	instr_t   id_instr;
	data_t    id_pc, id_rs1_data, id_rs2_data, id_imm;
	logic     wb_we;
	reg_idx_t wb_rd;
	data_t    wb_data;
	logic     ex_valid, ex_we, ex_branch_taken;
	data_t    ex_result;
	reg_idx_t ex_rd;

	// raw fields of one trace line
	logic [31:0] t_stall, t_valid, t_opc, t_f3, t_f7, t_rs1, t_rs2, t_rd;
	logic [31:0] t_pc, t_a, t_b, t_imm, t_wbwe, t_wbrd, t_wbdata;
	logic [31:0] e_valid, e_result, e_rd, e_we, e_br;

	expect_t exp_q[$];
	expect_t last_exp;
	int      errors = 0;
	int      compared = 0;
	int      cycles = 0;
	int      cycle_limit = 0;

	ex_stage dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycle_limit > 0 && cycles >= cycle_limit) begin
			$display("run timed out after %0d cycles before the trace was done", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	task automatic check_field(input string name, input logic [31:0] got,
			input logic [31:0] want);
		assert (got === want) else begin
			errors++;
			$display("ERR %0t: %s is %h, expected %h", $time, name, got, want);
		end
	endtask

	task automatic check_entry(input expect_t e);
		compared++;
		check_field("ex_valid", 32'(ex_valid), 32'(e.valid));
		check_field("ex_result", ex_result, e.result);
		check_field("ex_rd", 32'(ex_rd), 32'(e.rd));
		check_field("ex_we", 32'(ex_we), 32'(e.we));
		check_field("ex_branch_taken", 32'(ex_branch_taken), 32'(e.br));
	endtask

	task automatic drive_idle();
		stall       = 1'b0;
		id_valid    = 1'b0;
		id_instr    = '0;
		id_pc       = NULL;
		id_rs1_data = NULL;
		id_rs2_data = NULL;
		id_imm      = NULL;
		wb_we       = 1'b0;
		wb_rd       = '0;
		wb_data     = NULL;
	endtask

	task automatic apply_line();
		stall           = t_stall[0];
		id_valid        = t_valid[0];
		id_instr.opcode = opcode_t'(t_opc[6:0]);
		id_instr.funct3 = t_f3[2:0];
		id_instr.funct7 = t_f7[6:0];
		id_instr.rs1    = t_rs1[4:0];
		id_instr.rs2    = t_rs2[4:0];
		id_instr.rd     = t_rd[4:0];
		id_pc           = t_pc;
		id_rs1_data     = t_a;
		id_rs2_data     = t_b;
		id_imm          = t_imm;
		wb_we           = t_wbwe[0];
		wb_rd           = t_wbrd[4:0];
		wb_data         = t_wbdata;
	endtask

	task automatic queue_expected();
		expect_t e;
		e.valid  = e_valid[0];
		e.result = e_result;
		e.rd     = e_rd[4:0];
		e.we     = e_we[0];
		e.br     = e_br[0];
		exp_q.push_back(e);
	endtask

	task automatic count_trace_lines(output int lines);
		int    fd;
		int    n;
		string line;
		lines = 0;
		fd = $fopen(trace_file, "r");
		if (fd != 0) begin
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (n > 1 && line.substr(0, 0) != "#")
					lines++;
			end
			$fclose(fd);
		end
	endtask

	// skips comment and blank lines
	task automatic next_line(input int fd, output bit got);
		string line;
		int    n;
		got = 1'b0;
		while (!got && !$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n > 1 && line.substr(0, 0) != "#") begin
				n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
					t_stall, t_valid, t_opc, t_f3, t_f7, t_rs1, t_rs2, t_rd,
					t_pc, t_a, t_b, t_imm, t_wbwe, t_wbrd, t_wbdata,
					e_valid, e_result, e_rd, e_we, e_br);
				if (n == 20) begin
					got = 1'b1;
				end else begin
					errors++;
					$display("trace line could not be parsed: %s", line);
				end
			end
		end
	endtask

	initial begin
		int      fd;
		int      n;
		bit      got, pushed, prev_stall, prev_pushed, have_last, done;
		expect_t e;

		drive_idle();
		rst_n = 1'b0;
		count_trace_lines(n);
		cycle_limit = 2 * n + 50;
		fd = $fopen(trace_file, "r");
		done = (fd == 0);
		if (done) begin
			errors++;
			$display("could not open the trace file %s", trace_file);
		end
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		check_field("ex_valid", 32'(ex_valid), 32'd0);
		check_field("ex_we", 32'(ex_we), 32'd0);
		check_field("ex_branch_taken", 32'(ex_branch_taken), 32'd0);
		prev_stall  = 1'b1;
		prev_pushed = 1'b0;
		have_last   = 1'b0;
		while (!done) begin
			@(negedge clk);
			// the edge just passed shifts in a new entry or holds
			if (!prev_stall && exp_q.size() > (prev_pushed ? 1 : 0)) begin
				e = exp_q.pop_front();
				check_entry(e);
				last_exp  = e;
				have_last = 1'b1;
			end else if (prev_stall && have_last) begin
				check_entry(last_exp);
			end
			next_line(fd, got);
			if (got) begin
				apply_line();
				pushed = (t_stall[0] == 1'b0);
				if (pushed)
					queue_expected();
			end else begin
				drive_idle(); // drain the pipe
				pushed = 1'b0;
				done   = (exp_q.size() == 0);
			end
			prev_stall  = stall;
			prev_pushed = pushed;
		end
		$display("%0d entries compared, %0d errors", compared, errors);
		if (errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

/* vlog.f */
+incdir+common
common/rv_pkg.sv
execute/alu.sv
execute/alu_ctrl.sv
execute/fwd_unit.sv
execute/ex_mux.sv
src/ex_stage.sv
verification/tb_ex_stage.sv
